// ==== Makefile ====
SIM := obj_dir/Vegr_mesh_read_tb

.PHONY: all run check clean

all: check

# Rebuilt only when the file list or a source file changes
$(SIM): egr_mesh_read_top.f $(wildcard hw/*.sv tests/*.sv)
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module egr_mesh_read_tb -f egr_mesh_read_top.f \
		-o Vegr_mesh_read_tb

# The log decides pass or fail, the recipe status follows the grep
run: $(SIM)
	./$(SIM) | tee sim.log ; grep -q "Simulation finished: PASS" sim.log

check: run
	@grep -q "Simulation finished: PASS" sim.log && echo "check: sim.log reports a pass" \
		|| (echo "check: sim.log reports no pass"; exit 1)

clean:
	rm -rf obj_dir sim.log

// ==== egr_mesh_read_top.f ====
hw/egr_mesh_pkg.sv
hw/egr_sync_fifo.sv
hw/egr_rd_arbiter.sv
hw/mri.sv
hw/mesh_rd_line.sv
hw/egr_mesh_read_top.sv
tests/egr_mesh_read_assertions.sv
tests/egr_mesh_read_tb.sv

// ==== hw/egr_mesh_pkg.sv ====
`default_nettype none

package egr_mesh_pkg;

    ////////////////////////////////////////
    // Client and mesh widths
    ////////////////////////////////////////

    // Client roles are fixed (CPB, TMU, PRC)
    localparam int N_CLIENTS = 3;

    parameter int W_ADDR = 6;   // Mesh word address bits
    parameter int W_WORD = 32;  // Width of one mesh data word
    parameter int W_TAG  = 4;   // Tag carried by each client request

    // Enough bits to encode any client index
    localparam int W_CLIENT = $clog2(N_CLIENTS);

    ////////////////////////////////////////
    // Types
    ////////////////////////////////////////

    typedef logic [W_ADDR-1:0] addr_t;       // Mesh word address
    typedef logic [W_WORD-1:0] data_word_t;  // One mesh data word
    typedef logic [W_TAG-1:0]  tag_t;        // Client request tag

    // The request ID travels through the mesh and comes back with the data
    typedef struct packed {
        logic [W_CLIENT-1:0] client;  // Which client issued the read
        tag_t                tag;     // The client's own tag
    } req_id_t;

    // One entry of a client request queue
    typedef struct packed {
        addr_t addr;
        tag_t  tag;
    } rd_req_t;

    ////////////////////////////////////////
    // Default sizing
    ////////////////////////////////////////

    parameter int DEF_REQ_FIFO_DEPTH = 4;  // Entries per client request queue
    parameter int DEF_RSP_FIFO_DEPTH = 4;  // Entries in the response FIFO pair
    parameter int DEF_RD_LATENCY     = 2;  // Cycles from mesh read strobe to response

endpackage : egr_mesh_pkg

`default_nettype wire

// ==== hw/egr_mesh_read_top.sv ====
`timescale 1ns/1ps
`default_nettype none

// Read path of the egress block with mri in front of one mesh line
module egr_mesh_read_top #(
    parameter int REQ_FIFO_DEPTH = egr_mesh_pkg::DEF_REQ_FIFO_DEPTH,
    parameter int RSP_FIFO_DEPTH = egr_mesh_pkg::DEF_RSP_FIFO_DEPTH,
    parameter int RD_LATENCY     = egr_mesh_pkg::DEF_RD_LATENCY,
    parameter int MESH_DEPTH     = 1 << egr_mesh_pkg::W_ADDR  // Full address range
) (
    input  wire logic                               clk,
    input  wire logic                               rst_n,

    // Client ports
    input  wire logic [egr_mesh_pkg::N_CLIENTS-1:0] rreq_valid,
    input  egr_mesh_pkg::addr_t                     rreq_addr [egr_mesh_pkg::N_CLIENTS],
    input  egr_mesh_pkg::tag_t                      rreq_tag  [egr_mesh_pkg::N_CLIENTS],
    output logic [egr_mesh_pkg::N_CLIENTS-1:0]      rrsp_valid,
    output egr_mesh_pkg::data_word_t                rrsp_data,
    output egr_mesh_pkg::tag_t                      rrsp_tag,

    // Preload ports
    input  wire logic                               pl_valid,
    input  egr_mesh_pkg::addr_t                     pl_addr,
    input  egr_mesh_pkg::data_word_t                pl_data
);

    import egr_mesh_pkg::*;

    logic       mim_rd_valid;     // mri to mesh line
    addr_t      mim_rd_addr;
    req_id_t    mim_rd_req_id;
    logic       mim_rrsp_valid;   // Mesh line back to mri
    data_word_t mim_rrsp_data;
    req_id_t    mim_rrsp_req_id;

    mri #(
        .REQ_FIFO_DEPTH (REQ_FIFO_DEPTH),
        .RSP_FIFO_DEPTH (RSP_FIFO_DEPTH)
    ) i_mri (
        .clk             (clk),
        .rst_n           (rst_n),
        .rreq_valid      (rreq_valid),
        .rreq_addr       (rreq_addr),
        .rreq_tag        (rreq_tag),
        .mim_rd_valid    (mim_rd_valid),
        .mim_rd_addr     (mim_rd_addr),
        .mim_rd_req_id   (mim_rd_req_id),
        .mim_rrsp_valid  (mim_rrsp_valid),
        .mim_rrsp_data   (mim_rrsp_data),
        .mim_rrsp_req_id (mim_rrsp_req_id),
        .rrsp_valid      (rrsp_valid),
        .rrsp_data       (rrsp_data),
        .rrsp_tag        (rrsp_tag)
    );

    mesh_rd_line #(
        .RD_LATENCY (RD_LATENCY),
        .DEPTH      (MESH_DEPTH)
    ) i_mesh_rd_line (
        .clk             (clk),
        .rst_n           (rst_n),
        .pl_valid        (pl_valid),
        .pl_addr         (pl_addr),
        .pl_data         (pl_data),
        .mim_rd_valid    (mim_rd_valid),
        .mim_rd_addr     (mim_rd_addr),
        .mim_rd_req_id   (mim_rd_req_id),
        .mim_rrsp_valid  (mim_rrsp_valid),
        .mim_rrsp_data   (mim_rrsp_data),
        .mim_rrsp_req_id (mim_rrsp_req_id)
    );

endmodule : egr_mesh_read_top

`default_nettype wire

// ==== hw/egr_rd_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

// Round-robin arbiter over the client request queues
module egr_rd_arbiter #(
    parameter int N_REQ = 3
) (
    input  wire logic             clk,
    input  wire logic             rst_n,
    input  wire logic [N_REQ-1:0] req,    // Non-empty flags of the queues
    output logic      [N_REQ-1:0] grant,  // One-hot pop of the chosen queue
    output logic                  issue   // Registered flag that marks the mesh read
);

    localparam int W_IDX = (N_REQ > 1) ? $clog2(N_REQ) : 1;

    logic [W_IDX-1:0] rr_ptr;   // First requester to consider this cycle
    logic [W_IDX-1:0] gnt_idx;  // Index of the granted requester
    logic             gnt_any;  // Some requester won this cycle

    ////////////////////////////////////////
    // Grant selection
    ////////////////////////////////////////

    // Scan from the pointer and take the first queue with work
    always_comb begin
        int   idx;
        logic found;
        grant   = '0;
        gnt_idx = '0;
        found   = 1'b0;
        for (int i = 0; i < N_REQ; i++) begin
            idx = (int'(rr_ptr) + i) % N_REQ;  // Wrap around the requester ring
            if (req[idx] && !found) begin
                grant[idx] = 1'b1;
                gnt_idx    = W_IDX'(idx);
                found      = 1'b1;  // Later candidates lose
            end
        end
    end

    assign gnt_any = |grant;

    ////////////////////////////////////////
    // Pointer and issue register
    ////////////////////////////////////////

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            rr_ptr <= '0;
            issue  <= 1'b0;
        end else begin
            issue <= gnt_any;  // The popped head is on the mesh next cycle
            if (gnt_any) begin
                // The winner gets lowest priority next time
                rr_ptr <= (gnt_idx == W_IDX'(N_REQ - 1)) ? '0 : gnt_idx + 1'b1;
            end
        end
    end

endmodule : egr_rd_arbiter

`default_nettype wire

// ==== hw/egr_sync_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

// Single-clock FIFO with the head entry visible on d_out without a read
module egr_sync_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 4
) (
    input  wire logic     clk,
    input  wire logic     rst_n,
    input  wire logic     wr,     // Push d_in this cycle
    input  payload_t      d_in,
    input  wire logic     rd,     // Remove the head entry this cycle
    output payload_t      d_out,  // Current head entry
    output logic          empty,
    output logic          full
);

    localparam int W_PTR = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int W_CNT = $clog2(DEPTH + 1);

    payload_t             mem [DEPTH];  // Storage array
    logic [W_PTR-1:0]     wr_ptr;       // Next slot to write
    logic [W_PTR-1:0]     rd_ptr;       // Slot holding the head
    logic [W_CNT-1:0]     count;        // Number of stored entries
    logic                 do_wr;
    logic                 do_rd;

    assign empty = (count == '0);
    assign full  = (count == W_CNT'(DEPTH));

    // Guard both sides so a stray strobe cannot corrupt the pointers
    assign do_wr = wr && !full;
    assign do_rd = rd && !empty;

    assign d_out = mem[rd_ptr];

    // Payload storage written on each accepted push
    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= d_in;
        end
    end

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                // Wrap explicitly so DEPTH need not be a power of two
                wr_ptr <= (wr_ptr == W_PTR'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == W_PTR'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;  // Push only
                2'b01:   count <= count - 1'b1;  // Pop only
                default: count <= count;         // Both or neither leaves occupancy unchanged
            endcase
        end
    end

endmodule : egr_sync_fifo

`default_nettype wire

// ==== hw/mesh_rd_line.sv ====
`timescale 1ns/1ps
`default_nettype none

// Model of one mesh memory line with a fixed-latency read pipeline
module mesh_rd_line #(
    parameter int RD_LATENCY = 2,
    parameter int DEPTH      = 64
) (
    input  wire logic               clk,
    input  wire logic               rst_n,

    // Preload port used to fill the line before reads
    input  wire logic               pl_valid,
    input  egr_mesh_pkg::addr_t     pl_addr,
    input  egr_mesh_pkg::data_word_t pl_data,

    // Read request from mri
    input  wire logic               mim_rd_valid,
    input  egr_mesh_pkg::addr_t     mim_rd_addr,
    input  egr_mesh_pkg::req_id_t   mim_rd_req_id,

    // Read response back to mri
    output logic                    mim_rrsp_valid,
    output egr_mesh_pkg::data_word_t mim_rrsp_data,
    output egr_mesh_pkg::req_id_t   mim_rrsp_req_id
);

    import egr_mesh_pkg::*;

    data_word_t mem [DEPTH];  // Word storage

    logic       vld_pipe  [RD_LATENCY];  // Stage valid bits
    data_word_t data_pipe [RD_LATENCY];  // Stage data
    req_id_t    id_pipe   [RD_LATENCY];  // Stage request IDs

    ////////////////////////////////////////
    // Preload write
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (pl_valid) begin
            mem[pl_addr] <= pl_data;
        end
    end

    ////////////////////////////////////////
    // Read pipeline
    ////////////////////////////////////////

    // Valid bits move one stage per cycle
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < RD_LATENCY; s++) begin
                vld_pipe[s] <= 1'b0;
            end
        end else begin
            vld_pipe[0] <= mim_rd_valid;
            for (int s = 1; s < RD_LATENCY; s++) begin
                vld_pipe[s] <= vld_pipe[s-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        data_pipe[0] <= mem[mim_rd_addr];  // Array read in the first stage
        id_pipe[0]   <= mim_rd_req_id;
        for (int s = 1; s < RD_LATENCY; s++) begin
            data_pipe[s] <= data_pipe[s-1];
            id_pipe[s]   <= id_pipe[s-1];
        end
    end

    // Last stage is the response RD_LATENCY cycles after the strobe
    assign mim_rrsp_valid  = vld_pipe[RD_LATENCY-1];
    assign mim_rrsp_data   = data_pipe[RD_LATENCY-1];
    assign mim_rrsp_req_id = id_pipe[RD_LATENCY-1];

endmodule : mesh_rd_line

`default_nettype wire

// ==== hw/mri.sv ====
`timescale 1ns/1ps
`default_nettype none

// Mesh read interface between the egress clients and one mesh line
module mri #(
    parameter int REQ_FIFO_DEPTH = 4,
    parameter int RSP_FIFO_DEPTH = 4
) (
    input  wire logic                               clk,
    input  wire logic                               rst_n,

    // Client read requests, strobe per client
    input  wire logic [egr_mesh_pkg::N_CLIENTS-1:0] rreq_valid,
    input  egr_mesh_pkg::addr_t                     rreq_addr [egr_mesh_pkg::N_CLIENTS],
    input  egr_mesh_pkg::tag_t                      rreq_tag  [egr_mesh_pkg::N_CLIENTS],

    // Read issue toward the mesh line
    output logic                                    mim_rd_valid,
    output egr_mesh_pkg::addr_t                     mim_rd_addr,
    output egr_mesh_pkg::req_id_t                   mim_rd_req_id,

    // Read responses from the mesh line
    input  wire logic                               mim_rrsp_valid,
    input  egr_mesh_pkg::data_word_t                mim_rrsp_data,
    input  egr_mesh_pkg::req_id_t                   mim_rrsp_req_id,

    // Responses routed back to the clients
    output logic [egr_mesh_pkg::N_CLIENTS-1:0]      rrsp_valid,  // One-hot or zero
    output egr_mesh_pkg::data_word_t                rrsp_data,
    output egr_mesh_pkg::tag_t                      rrsp_tag
);

    import egr_mesh_pkg::*;

    ////////////////////////////////////////
    // Request queues
    ////////////////////////////////////////

    rd_req_t                req_in   [N_CLIENTS];  // Strobed request per client
    rd_req_t                req_head [N_CLIENTS];  // Head of each queue
    logic [N_CLIENTS-1:0]   req_empty;
    logic [N_CLIENTS-1:0]   req_full;              // Must never be high on a strobe
    logic [N_CLIENTS-1:0]   grant;                 // Pops the winning queue
    logic                   issue;
    rd_req_t                sel_req;               // Head of the granted queue
    logic [W_CLIENT-1:0]    sel_client;            // Index of the granted queue

    for (genvar c = 0; c < N_CLIENTS; c++) begin : g_req_q
        assign req_in[c] = '{addr: rreq_addr[c], tag: rreq_tag[c]};

        egr_sync_fifo #(
            .payload_t (rd_req_t),
            .DEPTH     (REQ_FIFO_DEPTH)
        ) i_req_fifo (
            .clk   (clk),
            .rst_n (rst_n),
            .wr    (rreq_valid[c]),
            .d_in  (req_in[c]),
            .rd    (grant[c]),
            .d_out (req_head[c]),
            .empty (req_empty[c]),
            .full  (req_full[c])
        );
    end

    egr_rd_arbiter #(
        .N_REQ (N_CLIENTS)
    ) i_rd_arbiter (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (~req_empty),
        .grant (grant),
        .issue (issue)
    );

    // One-hot mux of the granted head
    always_comb begin
        sel_req    = '0;
        sel_client = '0;
        for (int c = 0; c < N_CLIENTS; c++) begin
            if (grant[c]) begin
                sel_req    = req_head[c];
                sel_client = W_CLIENT'(c);
            end
        end
    end

    // Address and ID line up with the registered issue strobe
    always_ff @(posedge clk) begin
        if (|grant) begin
            mim_rd_addr   <= sel_req.addr;
            mim_rd_req_id <= '{client: sel_client, tag: sel_req.tag};
        end
    end

    assign mim_rd_valid = issue;

    ////////////////////////////////////////
    // Response FIFOs and routing
    ////////////////////////////////////////

    data_word_t rsp_data_head;
    req_id_t    rsp_id_head;
    logic       rsp_data_empty;
    logic       rsp_id_empty;
    logic       rsp_pop;  // Drain whenever a response is waiting

    egr_sync_fifo #(
        .payload_t (data_word_t),
        .DEPTH     (RSP_FIFO_DEPTH)
    ) i_rsp_data_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .wr    (mim_rrsp_valid),
        .d_in  (mim_rrsp_data),
        .rd    (rsp_pop),
        .d_out (rsp_data_head),
        .empty (rsp_data_empty),
        .full  ()
    );

    egr_sync_fifo #(
        .payload_t (req_id_t),
        .DEPTH     (RSP_FIFO_DEPTH)
    ) i_rsp_id_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .wr    (mim_rrsp_valid),
        .d_in  (mim_rrsp_req_id),
        .rd    (rsp_pop),
        .d_out (rsp_id_head),
        .empty (rsp_id_empty),
        .full  ()
    );

    assign rsp_pop = !rsp_data_empty && !rsp_id_empty;  // Both written together

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            rrsp_valid <= '0;
        end else begin
            // The client field of the ID picks the receiving client
            rrsp_valid <= rsp_pop ? (N_CLIENTS'(1) << rsp_id_head.client) : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rsp_pop) begin
            rrsp_data <= rsp_data_head;
            rrsp_tag  <= rsp_id_head.tag;  // Client sees only its own tag
        end
    end

endmodule : mri

`default_nettype wire

// ==== tests/egr_mesh_read_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

// Protocol checks on the mri boundary and its request queues
module egr_mesh_read_assertions (
    input  wire logic                               clk,
    input  wire logic                               rst_n,
    input  wire logic [egr_mesh_pkg::N_CLIENTS-1:0] rreq_valid,
    input  wire logic [egr_mesh_pkg::N_CLIENTS-1:0] req_full,    // Queue full flags
    input  wire logic [egr_mesh_pkg::N_CLIENTS-1:0] req_empty,   // Queue empty flags
    input  wire logic                               mim_rd_valid,
    input  wire logic                               mim_rrsp_valid,
    input  wire logic                               rsp_pop,     // Response FIFO pair pops
    input  wire logic [egr_mesh_pkg::N_CLIENTS-1:0] rrsp_valid
);

    ////////////////////////////////////////
    // Request side
    ////////////////////////////////////////

    // There is no back-pressure, so a strobe into a full queue would drop a request
    a_no_push_when_full : assert property (@(posedge clk) disable iff (!rst_n)
        (rreq_valid & req_full) == '0)
        else $error("request strobe into a full queue, strobes %b full %b", rreq_valid, req_full);

    ////////////////////////////////////////
    // Response side
    ////////////////////////////////////////

    // A popped response must carry an ID that names one real client
    a_rsp_onehot : assert property (@(posedge clk) disable iff (!rst_n)
        rsp_pop |=> $onehot(rrsp_valid))
        else $error("popped response not routed to exactly one client, rrsp_valid %b",
                    rrsp_valid);

    // While reset is held the strobes are quiet and every queue is empty
    a_reset_state : assert property (@(posedge clk)
        !rst_n |-> (rrsp_valid == '0 && !mim_rd_valid && !mim_rrsp_valid && &req_empty))
        else $error("strobes active or a request queue not empty during reset");

endmodule : egr_mesh_read_assertions

bind mri egr_mesh_read_assertions i_assertions (
    .clk            (clk),
    .rst_n          (rst_n),
    .rreq_valid     (rreq_valid),
    .req_full       (req_full),
    .req_empty      (req_empty),
    .mim_rd_valid   (mim_rd_valid),
    .mim_rrsp_valid (mim_rrsp_valid),
    .rsp_pop        (rsp_pop),
    .rrsp_valid     (rrsp_valid)
);

`default_nettype wire

// ==== tests/egr_mesh_read_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module egr_mesh_read_tb;

    import egr_mesh_pkg::*;

    logic                 clk = 1'b0;
    logic                 rst_n;
    logic [N_CLIENTS-1:0] rreq_valid;
    addr_t                rreq_addr [N_CLIENTS];
    tag_t                 rreq_tag  [N_CLIENTS];
    logic [N_CLIENTS-1:0] rrsp_valid;
    data_word_t           rrsp_data;
    tag_t                 rrsp_tag;
    logic                 pl_valid;
    addr_t                pl_addr;
    data_word_t           pl_data;

    integer  seed = 62;          // Seed for every $random call
    string   test_name;          // Shown in each error line
    rd_req_t exp_q [N_CLIENTS][$];  // Outstanding requests per client with the oldest first

    always #50 clk = ~clk;  // 100 ns period

    egr_mesh_read_top i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .rreq_valid (rreq_valid),
        .rreq_addr  (rreq_addr),
        .rreq_tag   (rreq_tag),
        .rrsp_valid (rrsp_valid),
        .rrsp_data  (rrsp_data),
        .rrsp_tag   (rrsp_tag),
        .pl_valid   (pl_valid),
        .pl_addr    (pl_addr),
        .pl_data    (pl_data)
    );

    ////////////////////////////////////////
    // Reference model and helpers
    ////////////////////////////////////////

    // Data pattern of the mesh line where every address bit changes the word
    function automatic data_word_t ref_word(input addr_t a);
        return data_word_t'((32'(a) * 32'h9E37_79B1) ^ 32'hA5C3_0F00 ^ {16'(a), 16'(~a)});
    endfunction

    function automatic int outstanding();
        int n;
        n = 0;
        for (int c = 0; c < N_CLIENTS; c++) begin
            n += exp_q[c].size();
        end
        return n;
    endfunction

    task automatic stop_on_failure(input string reason);
        $display("%s", reason);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            stop_on_failure($sformatf("error: test %s, %s: expected 0x%0h, actual 0x%0h",
                                      test_name, what, expected, actual));
        end
    endtask

    // Advance one cycle and drop all strobes 1 ns after the edge
    task automatic step();
        @(posedge clk);
        #1;
        rreq_valid = '0;
        pl_valid   = 1'b0;
    endtask

    // Raise one client strobe for the current cycle and log the expectation
    task automatic post_req(input logic [W_CLIENT-1:0] c, input addr_t a, input tag_t t);
        rd_req_t e;
        rreq_valid[c] = 1'b1;
        rreq_addr[c]  = a;
        rreq_tag[c]   = t;
        e.addr        = a;
        e.tag         = t;
        exp_q[c].push_back(e);
    endtask

    task automatic wait_drain(input int limit);
        int waited;
        waited = 0;
        while (outstanding() != 0 && waited < limit) begin
            step();
            waited++;
        end
        if (outstanding() != 0) begin
            stop_on_failure($sformatf(
                "timeout: %0d responses still missing after %0d cycles in test %s",
                outstanding(), limit, test_name));
        end
    endtask

    ////////////////////////////////////////
    // Response scoreboard
    ////////////////////////////////////////

    // Registered outputs are stable at the falling edge
    always @(negedge clk) begin : rsp_check
        rd_req_t             exp_e;
        logic [W_CLIENT-1:0] cl;
        if (!rst_n) begin
            check_value("rrsp_valid in reset", 32'd0, 32'(rrsp_valid));
        end else begin
            check_value("rrsp_valid one-hot", 32'd1, 32'($onehot0(rrsp_valid)));
            for (int c = 0; c < N_CLIENTS; c++) begin
                cl = W_CLIENT'(c);
                if (rrsp_valid[cl]) begin
                    if (exp_q[cl].size() == 0) begin
                        stop_on_failure($sformatf(
                            "client %0d got a response with no request pending in test %s",
                            c, test_name));
                    end else begin
                        exp_e = exp_q[cl].pop_front();  // Per-client order must hold
                        check_value($sformatf("client %0d tag", c),
                                    32'(exp_e.tag), 32'(rrsp_tag));
                        check_value($sformatf("client %0d data", c),
                                    ref_word(exp_e.addr), rrsp_data);
                    end
                end
            end
        end
    end

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    initial begin
        int                  last_strobe [N_CLIENTS];
        logic [W_CLIENT-1:0] cl;
        rst_n      = 1'b0;
        rreq_valid = '0;
        pl_valid   = 1'b0;
        pl_addr    = '0;
        pl_data    = '0;
        for (int c = 0; c < N_CLIENTS; c++) begin
            rreq_addr[c]   = '0;
            rreq_tag[c]    = '0;
            last_strobe[c] = -3;
        end
        test_name = "reset";
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        repeat (3) begin
            step();
            check_value("rrsp_valid after reset", 32'd0, 32'(rrsp_valid));  // Still idle
        end

        test_name = "preload";
        for (int a = 0; a < (1 << W_ADDR); a++) begin
            pl_valid = 1'b1;
            pl_addr  = addr_t'(a);
            pl_data  = ref_word(addr_t'(a));
            step();
        end

        test_name = "single_reads";
        for (int c = 0; c < N_CLIENTS; c++) begin
            post_req(W_CLIENT'(c), addr_t'(5 + 7 * c), tag_t'(c + 1));
            step();
            wait_drain(20);  // One client at a time
        end

        test_name = "concurrent_routing";
        for (int c = 0; c < N_CLIENTS; c++) begin
            post_req(W_CLIENT'(c), addr_t'(40 + c), tag_t'(8 + c));  // All in one cycle with distinct tags
        end
        step();
        wait_drain(30);

        // Each client strobes at most once every three cycles
        test_name = "random_order";
        for (int cyc = 0; cyc < 200; cyc++) begin
            for (int c = 0; c < N_CLIENTS; c++) begin
                cl = W_CLIENT'(c);
                if (cyc - last_strobe[c] >= 3 && ($random(seed) & 1) != 0) begin
                    post_req(cl, addr_t'($random(seed)), tag_t'($random(seed)));
                    last_strobe[c] = cyc;
                end
            end
            step();
        end
        wait_drain(100);

        test_name = "same_address";
        for (int c = 0; c < N_CLIENTS; c++) begin
            post_req(W_CLIENT'(c), addr_t'(33), tag_t'(12 + c));  // Back to back
            step();
        end
        wait_drain(30);

        test_name = "final";
        repeat (8) step();  // Idle so a stray response is still caught
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule : egr_mesh_read_tb

`default_nettype wire
